// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= axi_mux_tb
BUILD_DIR ?= build
LOG       ?= sim.log
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP BUILD_DIR LOG FILELIST VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "Done: no errors" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== list.f ====
+incdir+source
source/axi_mux_pkg.sv
source/axi_id_prepend.sv
source/axi_rr_arbiter.sv
source/axi_w_route_fifo.sv
source/axi_mux.sv
tb/axi_mux_props.sv
tb/axi_mux_checker.sv
tb/axi_mux_tb.sv

// ==== source/axi_id_prepend.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axi_mux_settings.svh"

module axi_id_prepend #(
  parameter int unsigned pre_id = 0
) (
  // Requests from one slave port
  input  axi_mux_pkg::slv_aw_t slv_aw_i,
  input  axi_mux_pkg::slv_ar_t slv_ar_i,
  // Responses from the shared master port
  input  axi_mux_pkg::mst_b_t  mst_b_i,
  input  axi_mux_pkg::mst_r_t  mst_r_i,
  // Requests with the port number on top of the ID
  output axi_mux_pkg::mst_aw_t mst_aw_o,
  output axi_mux_pkg::mst_ar_t mst_ar_o,
  // Responses with the port number removed
  output axi_mux_pkg::slv_b_t  slv_b_o,
  output axi_mux_pkg::slv_r_t  slv_r_o
);

  localparam axi_mux_pkg::port_sel_t pre_sel = axi_mux_pkg::port_sel_t'(pre_id);

  // Upper ID bits name the source port, the rest is copied
  always_comb begin : proc_prepend
    mst_aw_o.id   = {pre_sel, slv_aw_i.id};
    mst_aw_o.addr = slv_aw_i.addr;
    mst_aw_o.len  = slv_aw_i.len;
    mst_aw_o.size = slv_aw_i.size;
    mst_aw_o.qos  = slv_aw_i.qos;

    mst_ar_o.id   = {pre_sel, slv_ar_i.id};
    mst_ar_o.addr = slv_ar_i.addr;
    mst_ar_o.len  = slv_ar_i.len;
    mst_ar_o.size = slv_ar_i.size;
    mst_ar_o.qos  = slv_ar_i.qos;
  end

  // Only the low ID bits go back to the port
  always_comb begin : proc_strip
    slv_b_o.id   = mst_b_i.id[`AXI_SLV_ID_W-1:0];
    slv_b_o.resp = mst_b_i.resp;

    slv_r_o.id   = mst_r_i.id[`AXI_SLV_ID_W-1:0];
    slv_r_o.data = mst_r_i.data;
    slv_r_o.resp = mst_r_i.resp;
    slv_r_o.last = mst_r_i.last;
  end

endmodule

`default_nettype wire

// ==== source/axi_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axi_mux_settings.svh"

module axi_mux (
  input  wire                                          clk_i,
  input  wire                                          reset_i,
  // Slave ports, one entry per upstream master
  input  axi_mux_pkg::slv_aw_t [`AXI_MUX_PORTS-1:0]    slv_aw_i,
  input  wire                  [`AXI_MUX_PORTS-1:0]    slv_aw_valid_i,
  output logic                 [`AXI_MUX_PORTS-1:0]    slv_aw_ready_o,
  input  axi_mux_pkg::w_t      [`AXI_MUX_PORTS-1:0]    slv_w_i,
  input  wire                  [`AXI_MUX_PORTS-1:0]    slv_w_valid_i,
  output logic                 [`AXI_MUX_PORTS-1:0]    slv_w_ready_o,
  output axi_mux_pkg::slv_b_t  [`AXI_MUX_PORTS-1:0]    slv_b_o,
  output logic                 [`AXI_MUX_PORTS-1:0]    slv_b_valid_o,
  input  wire                  [`AXI_MUX_PORTS-1:0]    slv_b_ready_i,
  input  axi_mux_pkg::slv_ar_t [`AXI_MUX_PORTS-1:0]    slv_ar_i,
  input  wire                  [`AXI_MUX_PORTS-1:0]    slv_ar_valid_i,
  output logic                 [`AXI_MUX_PORTS-1:0]    slv_ar_ready_o,
  output axi_mux_pkg::slv_r_t  [`AXI_MUX_PORTS-1:0]    slv_r_o,
  output logic                 [`AXI_MUX_PORTS-1:0]    slv_r_valid_o,
  input  wire                  [`AXI_MUX_PORTS-1:0]    slv_r_ready_i,
  // Master port towards the memory slave
  output axi_mux_pkg::mst_aw_t                         mst_aw_o,
  output logic                                         mst_aw_valid_o,
  input  wire                                          mst_aw_ready_i,
  output axi_mux_pkg::w_t                              mst_w_o,
  output logic                                         mst_w_valid_o,
  input  wire                                          mst_w_ready_i,
  input  axi_mux_pkg::mst_b_t                          mst_b_i,
  input  wire                                          mst_b_valid_i,
  output logic                                         mst_b_ready_o,
  output axi_mux_pkg::mst_ar_t                         mst_ar_o,
  output logic                                         mst_ar_valid_o,
  input  wire                                          mst_ar_ready_i,
  input  axi_mux_pkg::mst_r_t                          mst_r_i,
  input  wire                                          mst_r_valid_i,
  output logic                                         mst_r_ready_o
);

  axi_mux_pkg::mst_aw_t [`AXI_MUX_PORTS-1:0] pre_aw;
  axi_mux_pkg::mst_ar_t [`AXI_MUX_PORTS-1:0] pre_ar;

  logic                   aw_gnt_valid;
  axi_mux_pkg::port_sel_t aw_gnt_idx;
  logic                   aw_fire;
  logic                   ar_gnt_valid;
  axi_mux_pkg::port_sel_t ar_gnt_idx;
  logic                   ar_fire;

  axi_mux_pkg::port_sel_t w_head;
  logic                   w_full;
  logic                   w_empty;
  logic                   w_last_fire;

  axi_mux_pkg::port_sel_t b_sel;
  axi_mux_pkg::port_sel_t r_sel;

  // Port number goes into the ID on the way out, and is removed on the way back
  for (genvar g = 0; g < `AXI_MUX_PORTS; g++) begin : gen_prepend
    axi_id_prepend #(
      .pre_id (g)
    ) u_prepend (
      .slv_aw_i (slv_aw_i[g]),
      .slv_ar_i (slv_ar_i[g]),
      .mst_b_i  (mst_b_i),
      .mst_r_i  (mst_r_i),
      .mst_aw_o (pre_aw[g]),
      .mst_ar_o (pre_ar[g]),
      .slv_b_o  (slv_b_o[g]),
      .slv_r_o  (slv_r_o[g])
    );
  end

  // AW goes out only while the route FIFO has room for its port number
  assign mst_aw_o       = pre_aw[aw_gnt_idx];
  assign mst_aw_valid_o = aw_gnt_valid && !w_full;
  assign aw_fire        = mst_aw_valid_o && mst_aw_ready_i;

  axi_rr_arbiter u_aw_arb (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_i       (slv_aw_valid_i),
    .ack_i       (aw_fire),
    .gnt_valid_o (aw_gnt_valid),
    .gnt_idx_o   (aw_gnt_idx)
  );

  axi_w_route_fifo u_w_route (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .push_i     (aw_fire),
    .push_idx_i (aw_gnt_idx),
    .pop_i      (w_last_fire),
    .head_idx_o (w_head),
    .full_o     (w_full),
    .empty_o    (w_empty)
  );

  // W follows the port at the FIFO head until its last beat
  assign mst_w_o       = slv_w_i[w_head];
  assign mst_w_valid_o = !w_empty && slv_w_valid_i[w_head];
  assign w_last_fire   = mst_w_valid_o && mst_w_ready_i && mst_w_o.last;

  assign mst_ar_o       = pre_ar[ar_gnt_idx];
  assign mst_ar_valid_o = ar_gnt_valid;
  assign ar_fire        = mst_ar_valid_o && mst_ar_ready_i;

  axi_rr_arbiter u_ar_arb (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_i       (slv_ar_valid_i),
    .ack_i       (ar_fire),
    .gnt_valid_o (ar_gnt_valid),
    .gnt_idx_o   (ar_gnt_idx)
  );

  // Readies only reach the selected port
  always_comb begin
    slv_aw_ready_o             = '0;
    slv_aw_ready_o[aw_gnt_idx] = aw_gnt_valid && !w_full && mst_aw_ready_i;
    slv_w_ready_o              = '0;
    slv_w_ready_o[w_head]      = !w_empty && mst_w_ready_i;
    slv_ar_ready_o             = '0;
    slv_ar_ready_o[ar_gnt_idx] = ar_gnt_valid && mst_ar_ready_i;
  end

  // Responses return to the port named in the upper ID bits
  assign b_sel = mst_b_i.id[`AXI_MST_ID_W-1 -: `AXI_MUX_SEL_W];
  assign r_sel = mst_r_i.id[`AXI_MST_ID_W-1 -: `AXI_MUX_SEL_W];

  always_comb begin
    slv_b_valid_o = '0;
    mst_b_ready_o = 1'b0;
    if (int'(b_sel) < `AXI_MUX_PORTS) begin
      slv_b_valid_o[b_sel] = mst_b_valid_i;
      mst_b_ready_o        = slv_b_ready_i[b_sel];
    end
    slv_r_valid_o = '0;
    mst_r_ready_o = 1'b0;
    if (int'(r_sel) < `AXI_MUX_PORTS) begin
      slv_r_valid_o[r_sel] = mst_r_valid_i;
      mst_r_ready_o        = slv_r_ready_i[r_sel];
    end
  end

endmodule

`default_nettype wire

// ==== source/axi_mux_pkg.sv ====
`default_nettype none

`include "axi_mux_settings.svh"

package axi_mux_pkg;

  // Widths that carry a meaning
  typedef logic [`AXI_SLV_ID_W-1:0]   slv_id_t;
  typedef logic [`AXI_MST_ID_W-1:0]   mst_id_t;
  typedef logic [`AXI_MUX_SEL_W-1:0]  port_sel_t;
  typedef logic [`AXI_ADDR_W-1:0]     addr_t;
  typedef logic [`AXI_DATA_W-1:0]     data_t;
  typedef logic [`AXI_DATA_W/8-1:0]   strb_t;
  typedef logic [`AXI_LEN_W-1:0]      len_t;
  typedef logic [1:0]                 resp_t;

  // Address channels, ID kept in the top bits
  typedef struct packed {
    slv_id_t    id;
    addr_t      addr;
    len_t       len;
    logic [2:0] size;
    logic [3:0] qos;
  } slv_aw_t;

  typedef struct packed {
    mst_id_t    id;
    addr_t      addr;
    len_t       len;
    logic [2:0] size;
    logic [3:0] qos;
  } mst_aw_t;

  typedef slv_aw_t slv_ar_t;
  typedef mst_aw_t mst_ar_t;

  // Write data has no ID, same on both sides
  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_t;

  typedef struct packed {
    slv_id_t id;
    resp_t   resp;
  } slv_b_t;

  typedef struct packed {
    mst_id_t id;
    resp_t   resp;
  } mst_b_t;

  typedef struct packed {
    slv_id_t id;
    data_t   data;
    resp_t   resp;
    logic    last;
  } slv_r_t;

  typedef struct packed {
    mst_id_t id;
    data_t   data;
    resp_t   resp;
    logic    last;
  } mst_r_t;

  // Occupancy of the W route FIFO
  typedef enum logic [1:0] {
    FIFO_EMPTY,
    FIFO_PARTIAL,
    FIFO_FULL
  } fifo_state_e;

endpackage

`default_nettype wire

// ==== source/axi_mux_settings.svh ====
`ifndef AXI_MUX_SETTINGS_SVH
`define AXI_MUX_SETTINGS_SVH

// Slave ports in front of the single master port
`define AXI_MUX_PORTS 4
`define AXI_MUX_SEL_W 2

// Nonzero when AXI_MUX_SEL_W can name every slave port
`define AXI_MUX_SEL_FITS ((1 << `AXI_MUX_SEL_W) >= `AXI_MUX_PORTS)

// Transaction ID widths, master side carries the port number on top
`define AXI_SLV_ID_W 2
`define AXI_MST_ID_W (`AXI_SLV_ID_W + `AXI_MUX_SEL_W)

// Nonzero when the master ID is exactly slave ID plus port number
`define AXI_MUX_ID_FITS (`AXI_MST_ID_W == (`AXI_SLV_ID_W + `AXI_MUX_SEL_W))

// Bus widths
`define AXI_ADDR_W 16
`define AXI_DATA_W 32
`define AXI_LEN_W 8

// Outstanding AW bursts whose W data is still pending
`define AXI_W_FIFO_DEPTH 4

`endif

// ==== source/axi_rr_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axi_mux_settings.svh"

module axi_rr_arbiter (
  input  wire                     clk_i,
  input  wire                     reset_i,
  input  wire [`AXI_MUX_PORTS-1:0] req_i,
  input  wire                     ack_i,
  output logic                    gnt_valid_o,
  output axi_mux_pkg::port_sel_t  gnt_idx_o
);

  // Last winner, search begins just after it
  axi_mux_pkg::port_sel_t last_q;

  // Grant held while its transfer waits for ready
  logic                   lock_q;
  axi_mux_pkg::port_sel_t lock_idx_q;

  always_comb begin : proc_grant
    axi_mux_pkg::port_sel_t cand;
    cand        = last_q;
    gnt_valid_o = 1'b0;
    gnt_idx_o   = last_q;
    if (lock_q) begin
      gnt_valid_o = req_i[lock_idx_q];
      gnt_idx_o   = lock_idx_q;
    end else begin
      // First requester after the last winner, wrapping around
      for (int i = 1; i <= `AXI_MUX_PORTS; i++) begin
        cand = axi_mux_pkg::port_sel_t'((int'(last_q) + i) % `AXI_MUX_PORTS);
        if (!gnt_valid_o && req_i[cand]) begin
          gnt_valid_o = 1'b1;
          gnt_idx_o   = cand;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // Port 0 gets first priority after reset
      last_q     <= axi_mux_pkg::port_sel_t'(`AXI_MUX_PORTS - 1);
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (gnt_valid_o && ack_i) begin
      last_q <= gnt_idx_o;
      lock_q <= 1'b0;
    end else begin
      lock_q     <= gnt_valid_o;
      lock_idx_q <= gnt_idx_o;
    end
  end

endmodule

`default_nettype wire

// ==== source/axi_w_route_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axi_mux_settings.svh"

module axi_w_route_fifo (
  input  wire                    clk_i,
  input  wire                    reset_i,
  input  wire                    push_i,
  input  axi_mux_pkg::port_sel_t push_idx_i,
  input  wire                    pop_i,
  output axi_mux_pkg::port_sel_t head_idx_o,
  output logic                   full_o,
  output logic                   empty_o
);

  localparam int unsigned ptr_w =
    (`AXI_W_FIFO_DEPTH > 1) ? $clog2(`AXI_W_FIFO_DEPTH) : 1;

  typedef logic [ptr_w-1:0] ptr_t;

  axi_mux_pkg::port_sel_t  mem_q [`AXI_W_FIFO_DEPTH];
  ptr_t                    wr_ptr_q;
  ptr_t                    rd_ptr_q;
  axi_mux_pkg::fifo_state_e state_q;
  axi_mux_pkg::fifo_state_e state_d;

  // Wraps also for depths that are not a power of two
  function automatic ptr_t ptr_inc(input ptr_t ptr);
    if (ptr == ptr_t'(`AXI_W_FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Occupancy only changes when one side moves alone
  always_comb begin
    state_d = state_q;
    if (push_i && !pop_i) begin
      state_d = (ptr_inc(wr_ptr_q) == rd_ptr_q) ? axi_mux_pkg::FIFO_FULL
                                                : axi_mux_pkg::FIFO_PARTIAL;
    end else if (pop_i && !push_i) begin
      state_d = (ptr_inc(rd_ptr_q) == wr_ptr_q) ? axi_mux_pkg::FIFO_EMPTY
                                                : axi_mux_pkg::FIFO_PARTIAL;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      state_q  <= axi_mux_pkg::FIFO_EMPTY;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_idx_i;
    end
  end

  assign head_idx_o = mem_q[rd_ptr_q];
  assign full_o     = (state_q == axi_mux_pkg::FIFO_FULL);
  assign empty_o    = (state_q == axi_mux_pkg::FIFO_EMPTY);

endmodule

`default_nettype wire

// ==== tb/axi_mux_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axi_mux_settings.svh"

module axi_mux_checker (
  input  wire                                       clk_i,
  input  wire                                       reset_i,
  input  axi_mux_pkg::slv_aw_t [`AXI_MUX_PORTS-1:0] slv_aw_i,
  input  axi_mux_pkg::slv_ar_t [`AXI_MUX_PORTS-1:0] slv_ar_i,
  input  axi_mux_pkg::w_t      [`AXI_MUX_PORTS-1:0] slv_w_i,
  input  axi_mux_pkg::slv_b_t  [`AXI_MUX_PORTS-1:0] slv_b_o,
  input  axi_mux_pkg::slv_r_t  [`AXI_MUX_PORTS-1:0] slv_r_o,
  input  wire [`AXI_MUX_PORTS-1:0] slv_aw_valid_i,
  input  wire [`AXI_MUX_PORTS-1:0] slv_aw_ready_o,
  input  wire [`AXI_MUX_PORTS-1:0] slv_w_valid_i,
  input  wire [`AXI_MUX_PORTS-1:0] slv_w_ready_o,
  input  wire [`AXI_MUX_PORTS-1:0] slv_ar_valid_i,
  input  wire [`AXI_MUX_PORTS-1:0] slv_ar_ready_o,
  input  wire [`AXI_MUX_PORTS-1:0] slv_b_valid_o,
  input  wire [`AXI_MUX_PORTS-1:0] slv_b_ready_i,
  input  wire [`AXI_MUX_PORTS-1:0] slv_r_valid_o,
  input  wire [`AXI_MUX_PORTS-1:0] slv_r_ready_i,
  input  axi_mux_pkg::mst_aw_t     mst_aw_o,
  input  axi_mux_pkg::mst_ar_t     mst_ar_o,
  input  axi_mux_pkg::w_t          mst_w_o,
  input  axi_mux_pkg::mst_b_t      mst_b_i,
  input  axi_mux_pkg::mst_r_t      mst_r_i,
  input  wire mst_aw_valid_o,
  input  wire mst_aw_ready_i,
  input  wire mst_w_valid_o,
  input  wire mst_w_ready_i,
  input  wire mst_ar_valid_o,
  input  wire mst_ar_ready_i,
  input  wire mst_b_valid_i,
  input  wire mst_b_ready_o,
  input  wire mst_r_valid_i,
  input  wire mst_r_ready_o,
  output int  err_cnt_o,
  output int  b_cnt_o,
  output int  r_cnt_o
);

  localparam int NP = `AXI_MUX_PORTS;
  localparam int SW = `AXI_SLV_ID_W;

  // Requests seen on each slave port, oldest first
  axi_mux_pkg::slv_aw_t aw_req [NP][$];
  axi_mux_pkg::slv_ar_t ar_req [NP][$];
  axi_mux_pkg::w_t      w_sent [NP][$];
  // Master-side bursts still waiting for their response
  axi_mux_pkg::mst_aw_t wr_out [$];
  axi_mux_pkg::mst_ar_t rd_out [$];
  int                   rd_beat [$];
  // W bursts expected on the master side, in AW order
  int                   ord_port [$];
  int                   ord_len [$];
  int                   w_beat;
  // Round-robin model, index 0 for AW and 1 for AR
  int                   arb_last [2];
  int                   arb_lk [2];
  logic                 arb_lock [2];

  task automatic fail(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    err_cnt_o++;
  endtask

  function automatic int rr_pick(input logic [NP-1:0] req, input int last);
    for (int i = 1; i <= NP; i++) begin
      if (req[(last + i) % NP]) return (last + i) % NP;
    end
    return last;
  endfunction

  // Port with the one slave-side transfer, or -1
  function automatic int src_of(input logic [NP-1:0] hs);
    int n;
    int k;
    n = 0;
    k = -1;
    for (int i = 0; i < NP; i++) begin
      if (hs[i]) begin
        n++;
        k = i;
      end
    end
    return (n == 1) ? k : -1;
  endfunction

  function automatic logic addr_ok(input axi_mux_pkg::mst_aw_t m,
                                   input axi_mux_pkg::slv_aw_t s, input int p);
    return m.id == {axi_mux_pkg::port_sel_t'(p), s.id} && m.addr == s.addr &&
           m.len == s.len && m.size == s.size && m.qos == s.qos;
  endfunction

  task automatic arb_step(input int ch, input logic [NP-1:0] req, input logic fire,
                          input int src);
    int exp;
    exp = arb_lock[ch] ? arb_lk[ch] : rr_pick(req, arb_last[ch]);
    if (fire) begin
      if (src != exp) begin
        fail($sformatf("%s grant to port %0d, expected port %0d",
                       (ch == 0) ? "AW" : "AR", src, exp));
      end
      arb_last[ch] = exp;
      arb_lock[ch] = 1'b0;
    end else begin
      arb_lock[ch] = |req;
      arb_lk[ch]   = exp;
    end
  endtask

  always @(posedge clk_i) begin
    int p;
    int e;
    logic [NP-1:0] one;
    axi_mux_pkg::slv_aw_t s;
    axi_mux_pkg::w_t w;
    if (reset_i) begin
      err_cnt_o = 0;
      b_cnt_o   = 0;
      r_cnt_o   = 0;
      w_beat    = 0;
      for (int i = 0; i < 2; i++) begin
        arb_last[i] = NP - 1;
        arb_lock[i] = 1'b0;
        arb_lk[i]   = 0;
      end
    end else begin
      for (int i = 0; i < NP; i++) begin
        if (slv_aw_valid_i[i] && slv_aw_ready_o[i]) aw_req[i].push_back(slv_aw_i[i]);
        if (slv_ar_valid_i[i] && slv_ar_ready_o[i]) ar_req[i].push_back(slv_ar_i[i]);
        if (slv_w_valid_i[i] && slv_w_ready_o[i]) w_sent[i].push_back(slv_w_i[i]);
      end

      p = -1;
      if (mst_aw_valid_o && mst_aw_ready_i) begin
        p = src_of(slv_aw_valid_i & slv_aw_ready_o);
        if (p < 0 || aw_req[p].size() == 0) begin
          fail("Master AW with no single source port");
        end else begin
          s = aw_req[p].pop_front();
          if (!addr_ok(mst_aw_o, s, p)) fail("Master AW ID or fields differ from request");
          ord_port.push_back(p);
          ord_len.push_back(int'(s.len));
          wr_out.push_back(mst_aw_o);
        end
      end
      arb_step(0, slv_aw_valid_i, mst_aw_valid_o && mst_aw_ready_i, p);

      p = -1;
      if (mst_ar_valid_o && mst_ar_ready_i) begin
        p = src_of(slv_ar_valid_i & slv_ar_ready_o);
        if (p < 0 || ar_req[p].size() == 0) begin
          fail("Master AR with no single source port");
        end else begin
          s = ar_req[p].pop_front();
          if (!addr_ok(mst_ar_o, s, p)) fail("Master AR ID or fields differ from request");
          rd_out.push_back(mst_ar_o);
          rd_beat.push_back(0);
        end
      end
      arb_step(1, slv_ar_valid_i, mst_ar_valid_o && mst_ar_ready_i, p);

      if (mst_w_valid_o && mst_w_ready_i) begin
        if (ord_port.size() == 0 || w_sent[ord_port[0]].size() == 0) begin
          fail("Master W beat with no matching burst");
        end else begin
          w = w_sent[ord_port[0]].pop_front();
          if (mst_w_o.data != w.data || mst_w_o.strb != w.strb ||
              mst_w_o.last != (w_beat == ord_len[0])) begin
            fail($sformatf("W beat %0d of port %0d wrong", w_beat, ord_port[0]));
          end
          if (w_beat == ord_len[0]) begin
            void'(ord_port.pop_front());
            void'(ord_len.pop_front());
            w_beat = 0;
          end else begin
            w_beat++;
          end
        end
      end

      // A response may only leave the master side when its port takes it
      if (mst_b_valid_i) begin
        p = int'(mst_b_i.id[`AXI_MST_ID_W-1 -: `AXI_MUX_SEL_W]);
        if (mst_b_ready_o != slv_b_ready_i[p]) begin
          fail("Master B ready does not follow the ready of its port");
        end
      end

      if (mst_r_valid_i) begin
        p = int'(mst_r_i.id[`AXI_MST_ID_W-1 -: `AXI_MUX_SEL_W]);
        if (mst_r_ready_o != slv_r_ready_i[p]) begin
          fail("Master R ready does not follow the ready of its port");
        end
      end

      if (mst_b_valid_i && mst_b_ready_o) begin
        p = int'(mst_b_i.id[`AXI_MST_ID_W-1 -: `AXI_MUX_SEL_W]);
        one = '0;
        one[p] = 1'b1;
        if (slv_b_valid_o != one || slv_b_o[p].id != mst_b_i.id[SW-1:0]) begin
          fail("B not routed to its port with the stripped ID");
        end
        e = -1;
        foreach (wr_out[i]) if (e < 0 && wr_out[i].id == mst_b_i.id) e = i;
        if (e < 0) begin
          fail("B with no outstanding write");
        end else begin
          if (slv_b_o[p].resp != wr_out[e].addr[1:0]) fail("B resp differs from address rule");
          wr_out.delete(e);
          b_cnt_o++;
        end
      end

      if (mst_r_valid_i && mst_r_ready_o) begin
        p = int'(mst_r_i.id[`AXI_MST_ID_W-1 -: `AXI_MUX_SEL_W]);
        one = '0;
        one[p] = 1'b1;
        if (slv_r_valid_o != one || slv_r_o[p].id != mst_r_i.id[SW-1:0]) begin
          fail("R not routed to its port with the stripped ID");
        end
        e = -1;
        foreach (rd_out[i]) if (e < 0 && rd_out[i].id == mst_r_i.id) e = i;
        if (e < 0) begin
          fail("R with no outstanding read");
        end else begin
          // Memory slave always answers OKAY
          if (slv_r_o[p].data != axi_mux_pkg::data_t'(rd_out[e].addr) +
                                 axi_mux_pkg::data_t'(rd_beat[e]) ||
              slv_r_o[p].resp != 2'b00 ||
              slv_r_o[p].last != (rd_beat[e] == int'(rd_out[e].len))) begin
            fail($sformatf("R beat %0d data, resp or last wrong", rd_beat[e]));
          end
          if (rd_beat[e] == int'(rd_out[e].len)) begin
            rd_out.delete(e);
            rd_beat.delete(e);
            r_cnt_o++;
          end else begin
            rd_beat[e]++;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb/axi_mux_props.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axi_mux_settings.svh"

module axi_mux_props (
  input wire                          clk_i,
  input wire                          reset_i,
  input axi_mux_pkg::mst_aw_t         mst_aw_o,
  input axi_mux_pkg::mst_ar_t         mst_ar_o,
  input wire                          mst_aw_valid_o,
  input wire                          mst_aw_ready_i,
  input wire                          mst_ar_valid_o,
  input wire                          mst_ar_ready_i,
  input wire                          mst_w_valid_o,
  input wire                          mst_w_ready_i,
  input wire [`AXI_MUX_PORTS-1:0]     slv_w_ready_o
);

  // Number of failed properties
  int fail_cnt = 0;

  // A raised master valid keeps its payload until the transfer
  aw_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    mst_aw_valid_o && !mst_aw_ready_i |=> mst_aw_valid_o && $stable(mst_aw_o))
    else begin
      fail_cnt++;
      $error("Master AW dropped or changed before its transfer");
    end

  ar_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    mst_ar_valid_o && !mst_ar_ready_i |=> mst_ar_valid_o && $stable(mst_ar_o))
    else begin
      fail_cnt++;
      $error("Master AR dropped or changed before its transfer");
    end

  w_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    mst_w_valid_o && !mst_w_ready_i |=> mst_w_valid_o)
    else begin
      fail_cnt++;
      $error("Master W valid dropped before its transfer");
    end

  // Route FIFO is empty out of reset
  w_quiet_in_reset: assert property (@(posedge clk_i)
    reset_i |=> !mst_w_valid_o && (slv_w_ready_o == '0))
    else begin
      fail_cnt++;
      $error("W channel active during reset");
    end

endmodule

bind axi_mux axi_mux_props props_i (.*);

`default_nettype wire

// ==== tb/axi_mux_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axi_mux_settings.svh"

module axi_mux_tb;

  localparam int NP     = `AXI_MUX_PORTS;
  localparam int BURSTS = 60;
  localparam int LIMIT  = NP * 120 * 4 * 8 + 2000;

  logic clk_i;
  logic reset_i;
  axi_mux_pkg::slv_aw_t [NP-1:0] slv_aw_i;
  axi_mux_pkg::w_t      [NP-1:0] slv_w_i;
  axi_mux_pkg::slv_b_t  [NP-1:0] slv_b_o;
  axi_mux_pkg::slv_ar_t [NP-1:0] slv_ar_i;
  axi_mux_pkg::slv_r_t  [NP-1:0] slv_r_o;
  logic [NP-1:0] slv_aw_valid_i, slv_aw_ready_o, slv_w_valid_i, slv_w_ready_o;
  logic [NP-1:0] slv_b_valid_o, slv_b_ready_i, slv_ar_valid_i, slv_ar_ready_o;
  logic [NP-1:0] slv_r_valid_o, slv_r_ready_i;
  axi_mux_pkg::mst_aw_t mst_aw_o;
  axi_mux_pkg::w_t      mst_w_o;
  axi_mux_pkg::mst_b_t  mst_b_i;
  axi_mux_pkg::mst_ar_t mst_ar_o;
  axi_mux_pkg::mst_r_t  mst_r_i;
  logic mst_aw_valid_o, mst_aw_ready_i, mst_w_valid_o, mst_w_ready_i, mst_b_valid_i;
  logic mst_b_ready_o, mst_ar_valid_o, mst_ar_ready_i, mst_r_valid_i, mst_r_ready_o;

  int   err_cnt;
  int   b_cnt;
  int   r_cnt;
  int   cycles;
  logic timed_out;
  logic [15:0] lfsr;

  // Transfers seen at the last rising edge
  logic          run;
  logic [NP-1:0] aw_hs, w_hs, ar_hs;
  logic          m_aw_hs, m_wl_hs, m_ar_hs, m_b_hs, m_r_hs;
  axi_mux_pkg::mst_aw_t m_aw_q;
  axi_mux_pkg::mst_ar_t m_ar_q;

  // Master state per port
  int                 aw_n [NP];
  int                 ar_n [NP];
  int                 w_beat [NP];
  axi_mux_pkg::len_t  w_len [NP][$];
  // Memory slave state
  axi_mux_pkg::mst_aw_t slv_aw_q [$];
  axi_mux_pkg::mst_b_t  slv_b_q [$];
  axi_mux_pkg::mst_ar_t slv_ar_q [$];
  int                   r_beat;

  // x^16 + x^14 + x^13 + x^11, one step per bit
  function automatic logic [31:0] rnd(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  axi_mux axi_mux_i (.*);

  axi_mux_checker checker_i (
    .*,
    .err_cnt_o (err_cnt),
    .b_cnt_o   (b_cnt),
    .r_cnt_o   (r_cnt)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    run     <= !reset_i;
    aw_hs   <= slv_aw_valid_i & slv_aw_ready_o;
    w_hs    <= slv_w_valid_i & slv_w_ready_o;
    ar_hs   <= slv_ar_valid_i & slv_ar_ready_o;
    m_aw_hs <= mst_aw_valid_o & mst_aw_ready_i;
    m_wl_hs <= mst_w_valid_o & mst_w_ready_i & mst_w_o.last;
    m_ar_hs <= mst_ar_valid_o & mst_ar_ready_i;
    m_b_hs  <= mst_b_valid_i & mst_b_ready_o;
    m_r_hs  <= mst_r_valid_i & mst_r_ready_o;
    m_aw_q  <= mst_aw_o;
    m_ar_q  <= mst_ar_o;
  end

  // Random masters and memory slave, driven on the falling edge
  initial begin
    axi_mux_pkg::mst_aw_t wr_aw;
    lfsr = 16'd8572;
    slv_aw_i = '0;
    slv_w_i = '0;
    slv_ar_i = '0;
    slv_aw_valid_i = '0;
    slv_w_valid_i = '0;
    slv_ar_valid_i = '0;
    slv_b_ready_i = '0;
    slv_r_ready_i = '0;
    mst_b_i = '0;
    mst_r_i = '0;
    mst_aw_ready_i = 1'b0;
    mst_w_ready_i = 1'b0;
    mst_ar_ready_i = 1'b0;
    mst_b_valid_i = 1'b0;
    mst_r_valid_i = 1'b0;
    r_beat = 0;
    for (int p = 0; p < NP; p++) begin
      aw_n[p] = 0;
      ar_n[p] = 0;
      w_beat[p] = 0;
    end
    forever begin
      @(negedge clk_i);
      if (run) begin
        for (int p = 0; p < NP; p++) begin
          if (aw_hs[p]) slv_aw_valid_i[p] = 1'b0;
          if (!slv_aw_valid_i[p] && aw_n[p] < BURSTS && rnd(2) == 0) begin
            slv_aw_i[p].id   = axi_mux_pkg::slv_id_t'(rnd(2));
            slv_aw_i[p].addr = axi_mux_pkg::addr_t'(rnd(16));
            slv_aw_i[p].len  = axi_mux_pkg::len_t'(rnd(2));
            slv_aw_i[p].size = 3'd2;
            slv_aw_i[p].qos  = 4'(rnd(4));
            slv_aw_valid_i[p] = 1'b1;
            w_len[p].push_back(slv_aw_i[p].len);
            aw_n[p]++;
          end
          if (w_hs[p]) begin
            slv_w_valid_i[p] = 1'b0;
            if (slv_w_i[p].last) begin
              void'(w_len[p].pop_front());
              w_beat[p] = 0;
            end else begin
              w_beat[p]++;
            end
          end
          if (!slv_w_valid_i[p] && w_len[p].size() > 0 && rnd(1) == 1) begin
            slv_w_i[p].data = rnd(32);
            slv_w_i[p].strb = axi_mux_pkg::strb_t'(rnd(4));
            slv_w_i[p].last = (w_beat[p] == int'(w_len[p][0]));
            slv_w_valid_i[p] = 1'b1;
          end
          if (ar_hs[p]) slv_ar_valid_i[p] = 1'b0;
          if (!slv_ar_valid_i[p] && ar_n[p] < BURSTS && rnd(2) == 0) begin
            slv_ar_i[p].id   = axi_mux_pkg::slv_id_t'(rnd(2));
            slv_ar_i[p].addr = axi_mux_pkg::addr_t'(rnd(16));
            slv_ar_i[p].len  = axi_mux_pkg::len_t'(rnd(2));
            slv_ar_i[p].size = 3'd2;
            slv_ar_i[p].qos  = 4'(rnd(4));
            slv_ar_valid_i[p] = 1'b1;
            ar_n[p]++;
          end
        end
        slv_b_ready_i = NP'(rnd(NP));
        slv_r_ready_i = NP'(rnd(NP));

        // Memory slave answers each write after its last W beat
        if (m_aw_hs) slv_aw_q.push_back(m_aw_q);
        if (m_wl_hs && slv_aw_q.size() > 0) begin
          wr_aw = slv_aw_q.pop_front();
          slv_b_q.push_back('{id: wr_aw.id, resp: wr_aw.addr[1:0]});
        end
        if (m_b_hs) mst_b_valid_i = 1'b0;
        if (!mst_b_valid_i && slv_b_q.size() > 0 && rnd(1) == 1) begin
          mst_b_i = slv_b_q.pop_front();
          mst_b_valid_i = 1'b1;
        end
        if (m_ar_hs) slv_ar_q.push_back(m_ar_q);
        if (m_r_hs) begin
          mst_r_valid_i = 1'b0;
          if (mst_r_i.last) begin
            void'(slv_ar_q.pop_front());
            r_beat = 0;
          end else begin
            r_beat++;
          end
        end
        if (!mst_r_valid_i && slv_ar_q.size() > 0 && rnd(1) == 1) begin
          mst_r_i.id   = slv_ar_q[0].id;
          mst_r_i.data = axi_mux_pkg::data_t'(slv_ar_q[0].addr) + axi_mux_pkg::data_t'(r_beat);
          mst_r_i.resp = 2'b00;
          mst_r_i.last = (r_beat == int'(slv_ar_q[0].len));
          mst_r_valid_i = 1'b1;
        end
        mst_aw_ready_i = rnd(1) == 1;
        mst_w_ready_i  = rnd(1) == 1;
        mst_ar_ready_i = rnd(1) == 1;
      end
    end
  end

  initial begin
    reset_i = 1'b1;
    timed_out = 1'b0;
    cycles = 0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    while (!(b_cnt == NP * BURSTS && r_cnt == NP * BURSTS) && !timed_out) begin
      @(posedge clk_i);
      cycles++;
      if (cycles >= LIMIT) timed_out = 1'b1;
    end
    repeat (8) @(posedge clk_i);
    if (timed_out) begin
      $display("Timeout: bursts still open after %0d cycles", LIMIT);
    end
    $display("Errors: %0d check failures, %0d assertion failures, %0d timeouts",
             err_cnt, axi_mux_i.props_i.fail_cnt, int'(timed_out));
    if (err_cnt == 0 && axi_mux_i.props_i.fail_cnt == 0 && !timed_out) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
